// File: src/video_timing_pkg.sv
// panel geometry and sync types for a 320x240 serial-RGB panel
// each pixel is three pixclk cycles on the bus, red then green then blue
// counters are 10 bits, so totals must stay below 1024
package video_timing_pkg;

  // horizontal geometry in pixels
  localparam int H_ACTIVE = 320;
  localparam int H_FRONT  = 20;
  localparam int H_SYNC   = 30;
  localparam int H_BACK   = 38;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

  // vertical geometry in lines
  localparam int V_ACTIVE = 240;
  localparam int V_FRONT  = 4;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 14;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  // byte phase within a pixel
  localparam int BYTES_PER_PIXEL = 3;
  localparam int PHASE_W         = 2;

  // counter widths
  localparam int H_W = 10;
  localparam int V_W = 10;

  // panel control lines, syncs are active low
  typedef struct packed {
    logic hsync_n;
    logic vsync_n;
    logic den;
  } lcd_sync_t;

  // position of the byte currently being generated
  // phase 0 red, 1 green, 2 blue
  typedef struct packed {
    logic [H_W-1:0]     h_pos;
    logic [V_W-1:0]     v_pos;
    logic [PHASE_W-1:0] phase;
  } pixel_pos_t;

endpackage

// File: src/pixel_pkg.sv
// colour types and test pattern constants
// channel index doubles as the byte phase on the bus
// BAND_WIDTH must be a power of two
package pixel_pkg;

  // one byte per colour, red in the top byte
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

  // channel order matches the byte order on lcd_dat
  localparam int CH_RED     = 0;
  localparam int CH_GREEN   = 1;
  localparam int CH_BLUE    = 2;
  localparam int N_CHANNELS = 3;

  // rainbow pattern
  // five bands across the active width, black beyond
  localparam int BAND_WIDTH = 64;
  localparam int N_BANDS    = 5;

endpackage

// File: src/lcd_timing_gen.sv
// raster counters for the serial-RGB panel, one byte phase per pixclk
// pos and sync are registered and describe the same byte in every cycle
// after reset the raster starts at the first active byte
`timescale 1ns/10ps

module lcd_timing_gen
(
  input  logic                         pixclk,
  input  logic                         rst_n,
  output video_timing_pkg::pixel_pos_t pos,
  output video_timing_pkg::lcd_sync_t  sync
);
  import video_timing_pkg::*;

  pixel_pos_t pos_nxt;

  // sync levels for a given raster position
  function automatic lcd_sync_t sync_of(input pixel_pos_t p);
    lcd_sync_t s;
    // hsync covers the pixels after the front porch
    s.hsync_n = !((p.h_pos >= H_W'(H_ACTIVE + H_FRONT)) &&
                  (p.h_pos <  H_W'(H_ACTIVE + H_FRONT + H_SYNC)));
    // vsync is low for whole lines, all phases included
    s.vsync_n = !((p.v_pos >= V_W'(V_ACTIVE + V_FRONT)) &&
                  (p.v_pos <  V_W'(V_ACTIVE + V_FRONT + V_SYNC)));
    s.den     = (p.h_pos < H_W'(H_ACTIVE)) && (p.v_pos < V_W'(V_ACTIVE));
    return s;
  endfunction

  // phase -> h_pos -> v_pos carry chain
  always_comb
  begin
    pos_nxt = pos;
    if (pos.phase == PHASE_W'(BYTES_PER_PIXEL - 1))
    begin
      pos_nxt.phase = '0;
      if (pos.h_pos == H_W'(H_TOTAL - 1))
      begin
        pos_nxt.h_pos = '0;
        // frame wrap
        if (pos.v_pos == V_W'(V_TOTAL - 1))
        begin
          pos_nxt.v_pos = '0;
        end
        else
        begin
          pos_nxt.v_pos = pos.v_pos + 1'b1;
        end
      end
      else
      begin
        pos_nxt.h_pos = pos.h_pos + 1'b1;
      end
    end
    else
    begin
      pos_nxt.phase = pos.phase + 1'b1;
    end
  end

  // sync decoded from the next state so both registers line up
  always_ff @(posedge pixclk)
  begin
    if (!rst_n)
    begin
      pos  <= '0;
      sync <= sync_of('0);
    end
    else
    begin
      pos  <= pos_nxt;
      sync <= sync_of(pos_nxt);
    end
  end

  // only three phases per pixel
  a_phase_range : assert property (
    @(posedge pixclk) disable iff (!rst_n)
    pos.phase != PHASE_W'(BYTES_PER_PIXEL)
  ) else $error("lcd_timing_gen: phase reached %0d", pos.phase);

  // line counter wraps before H_TOTAL
  a_h_range : assert property (
    @(posedge pixclk) disable iff (!rst_n)
    pos.h_pos < H_W'(H_TOTAL)
  ) else $error("lcd_timing_gen: h_pos %0d out of range", pos.h_pos);

endmodule

// File: src/colour_channel.sv
// intensity of one colour for the current pixel
// rainbow uses h_pos only; blanking happens downstream via den
// CHANNEL selects red, green or blue as in pixel_pkg
`timescale 1ns/10ps

module colour_channel
#(
  parameter int CHANNEL = 0
)
(
  input  logic                             pixclk,
  input  logic                             rst_n,
  input  logic [video_timing_pkg::H_W-1:0] h_pos,
  input  logic                             pattern_sel,
  input  logic [7:0]                       fill,
  output logic [7:0]                       level
);
  import pixel_pkg::*;

  // band number is h_pos above the ramp bits
  localparam int BAND_BITS  = $clog2(BAND_WIDTH);
  localparam int BAND_IDX_W = $bits(h_pos) - BAND_BITS;

  logic [BAND_IDX_W-1:0] band;
  logic [N_CHANNELS-1:0] lit;
  logic [7:0]            ramp;
  logic [7:0]            level_nxt;

  // which colours a band turns on
  function automatic logic [N_CHANNELS-1:0] band_lights(input logic [BAND_IDX_W-1:0] b);
    logic [N_CHANNELS-1:0] m;
    m = '0;
    case (b)
      0: m[CH_RED] = 1'b1;
      1: m[CH_GREEN] = 1'b1;
      2: m[CH_BLUE] = 1'b1;
      3: m = '1;
      4:
      begin
        m[CH_RED]  = 1'b1;
        m[CH_BLUE] = 1'b1;
      end
      default: m = '0;
    endcase
    return m;
  endfunction

  assign band = h_pos[$bits(h_pos)-1:BAND_BITS];

  // low bits of h_pos as a rising ramp within the band
  assign ramp = {h_pos[BAND_BITS-1:0], {(8 - BAND_BITS){1'b0}}};

  // black past the last band
  assign lit = (band < BAND_IDX_W'(N_BANDS)) ? band_lights(band) : '0;

  // solid fill overrides the rainbow
  assign level_nxt = pattern_sel  ? fill :
                     lit[CHANNEL] ? ramp : 8'd0;

  always_ff @(posedge pixclk)
  begin
    if (!rst_n)
    begin
      level <= '0;
    end
    else
    begin
      level <= level_nxt;
    end
  end

endmodule

// File: src/lcd_serializer.sv
// puts the three colour bytes on the 8-bit bus, one per pixclk
// colour arrives one cycle after its position, syncs two cycles early
// bytes outside den are driven as 0
`timescale 1ns/10ps

module lcd_serializer
(
  input  logic                                 pixclk,
  input  logic                                 rst_n,
  input  logic [video_timing_pkg::PHASE_W-1:0] phase,
  input  video_timing_pkg::lcd_sync_t          sync_in,
  input  pixel_pkg::rgb_t                      colour,
  output logic [7:0]                           lcd_dat,
  output logic                                 lcd_hsync_n,
  output logic                                 lcd_vsync_n,
  output logic                                 lcd_den
);
  import video_timing_pkg::*;
  import pixel_pkg::*;

  // idle bus levels, syncs high and no data
  localparam lcd_sync_t SYNC_IDLE = '{hsync_n: 1'b1, vsync_n: 1'b1, den: 1'b0};

  logic [PHASE_W-1:0] phase_d1;
  lcd_sync_t          sync_d1;
  lcd_sync_t          sync_d2;
  logic [7:0]         byte_sel;

  // phase_d1 lines up with the channel outputs
  always_comb
  begin
    case (phase_d1)
      PHASE_W'(CH_RED):   byte_sel = colour.red;
      PHASE_W'(CH_GREEN): byte_sel = colour.green;
      PHASE_W'(CH_BLUE):  byte_sel = colour.blue;
      default:            byte_sel = 8'd0;
    endcase
  end

  always_ff @(posedge pixclk)
  begin
    if (!rst_n)
    begin
      phase_d1 <= '0;
      sync_d1  <= SYNC_IDLE;
      sync_d2  <= SYNC_IDLE;
      lcd_dat  <= '0;
    end
    else
    begin
      phase_d1 <= phase;
      sync_d1  <= sync_in;
      // second stage matches the data register
      sync_d2  <= sync_d1;
      // blank outside the active area
      lcd_dat  <= sync_d1.den ? byte_sel : 8'd0;
    end
  end

  assign lcd_hsync_n = sync_d2.hsync_n;
  assign lcd_vsync_n = sync_d2.vsync_n;
  assign lcd_den     = sync_d2.den;

  // each active run starts on a red byte
  // phase of the shown byte was in phase_d1 one cycle back
  a_den_on_red : assert property (
    @(posedge pixclk) disable iff (!rst_n)
    $rose(lcd_den) |-> ($past(phase_d1) == PHASE_W'(CH_RED))
  ) else $error("lcd_serializer: den rose on phase %0d", $past(phase_d1));

endmodule

// File: src/lcd_panel_top.sv
// serial-RGB LCD pattern subsystem, 8-bit bus, three bytes per pixel
// pixclk comes from outside; dclk to the panel is pixclk itself
// pattern_sel and solid_colour take effect on lcd_dat two cycles later
`timescale 1ns/10ps

module lcd_panel_top
(
  input  logic            pixclk,
  input  logic            rst_n,
  input  logic            pattern_sel,
  input  pixel_pkg::rgb_t solid_colour,
  output logic [7:0]      lcd_dat,
  output logic            lcd_hsync_n,
  output logic            lcd_vsync_n,
  output logic            lcd_den
);
  import video_timing_pkg::*;
  import pixel_pkg::*;

  pixel_pos_t pos;
  lcd_sync_t  sync;

  // ascending index puts red at index 0, same as CH_RED
  logic [0:N_CHANNELS-1][7:0] fill_bytes;
  logic [0:N_CHANNELS-1][7:0] level_bytes;
  rgb_t                       colour;

  assign fill_bytes = solid_colour;
  assign colour     = level_bytes;

  // raster counters and syncs
  lcd_timing_gen i_lcd_timing_gen
  (
    .pixclk (pixclk),
    .rst_n  (rst_n),
    .pos    (pos),
    .sync   (sync)
  );

  // one intensity unit per colour
  for (genvar ch = 0; ch < N_CHANNELS; ch++)
  begin : g_channel
    colour_channel #(.CHANNEL(ch)) i_colour_channel
    (
      .pixclk      (pixclk),
      .rst_n       (rst_n),
      .h_pos       (pos.h_pos),
      .pattern_sel (pattern_sel),
      .fill        (fill_bytes[ch]),
      .level       (level_bytes[ch])
    );
  end

  // byte mux and sync alignment
  lcd_serializer i_lcd_serializer
  (
    .pixclk      (pixclk),
    .rst_n       (rst_n),
    .phase       (pos.phase),
    .sync_in     (sync),
    .colour      (colour),
    .lcd_dat     (lcd_dat),
    .lcd_hsync_n (lcd_hsync_n),
    .lcd_vsync_n (lcd_vsync_n),
    .lcd_den     (lcd_den)
  );

endmodule

// File: sim/tb_lcd_panel.sv
// directed tests for the serial-RGB LCD subsystem with outputs sampled on the falling edge
// expected values come from the 320x240 raster and the five-band rainbow rule
// a full frame is 318240 cycles, so the frame test alone runs about 13 ms of sim time
`timescale 1ns/10ps

module tb_lcd_panel;
  import pixel_pkg::*;

  // raster in bus cycles at three bytes per pixel
  localparam int LINE_CYCLES  = 408 * 3;
  localparam int FRAME_CYCLES = 260 * LINE_CYCLES;
  localparam int HSYNC_LOW    = 30 * 3;
  localparam int VSYNC_LOW    = 2 * LINE_CYCLES;
  localparam int ACTIVE_BYTES = 320 * 3;
  localparam int BLANK_BYTES  = LINE_CYCLES - ACTIVE_BYTES;
  localparam int ACTIVE_LINES = 240;

  // output selectors for the edge helpers
  localparam int SEL_HSYNC = 0;
  localparam int SEL_VSYNC = 1;
  localparam int SEL_DEN   = 2;

  logic        pixclk;
  logic        rst_n;
  logic        pattern_sel;
  rgb_t        solid_colour;
  logic [7:0]  lcd_dat;
  logic        lcd_hsync_n;
  logic        lcd_vsync_n;
  logic        lcd_den;
  logic [15:0] lfsr_state;
  int          errors;
  int          timeouts;

  lcd_panel_top i_lcd_panel_top
  (
    .pixclk       (pixclk),
    .rst_n        (rst_n),
    .pattern_sel  (pattern_sel),
    .solid_colour (solid_colour),
    .lcd_dat      (lcd_dat),
    .lcd_hsync_n  (lcd_hsync_n),
    .lcd_vsync_n  (lcd_vsync_n),
    .lcd_den      (lcd_den)
  );

  // 40 ns period
  always #20 pixclk = ~pixclk;

  function automatic logic sig_value(input int sel);
    case (sel)
      SEL_HSYNC: return lcd_hsync_n;
      SEL_VSYNC: return lcd_vsync_n;
      default:   return lcd_den;
    endcase
  endfunction

  function automatic string sig_name(input int sel);
    case (sel)
      SEL_HSYNC: return "lcd_hsync_n";
      SEL_VSYNC: return "lcd_vsync_n";
      default:   return "lcd_den";
    endcase
  endfunction

  // taps x^16 + x^14 + x^13 + x^11 + 1 with shifts toward the msb
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // band rule gives red, green, blue, white and magenta, then black
  function automatic logic [7:0] band_byte(input int x, input int ch);
    bit lit;
    case (x / 64)
      0:       lit = (ch == 0);
      1:       lit = (ch == 1);
      2:       lit = (ch == 2);
      3:       lit = 1'b1;
      4:       lit = (ch != 1);
      default: lit = 1'b0;
    endcase
    // ramp of 0, 4, 8 .. 252 inside each band
    return lit ? 8'((x % 64) * 4) : 8'd0;
  endfunction

  task automatic report_mismatch(input string test, input int expected, input int actual);
    $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
    errors++;
  endtask

  // one lfsr step per colour bit with red bits first
  task automatic draw_colour(output rgb_t c);
    logic [23:0] bits;
    int i;
    bits = '0;
    for (i = 0; i < 24; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[22:0], lfsr_state[0]};
    end
    c = bits;
  endtask

  task automatic wait_edge(input int sel, input bit rising, input int limit, output bit found);
    logic prev;
    logic cur;
    int n;
    found = 1'b0;
    prev = sig_value(sel);
    n = 0;
    while (!found && n < limit)
    begin
      @(negedge pixclk);
      cur = sig_value(sel);
      n++;
      if (rising ? (!prev && cur) : (prev && !cur))
        found = 1'b1;
      prev = cur;
    end
    if (!found)
    begin
      $display("timeout: no %s edge of %s within %0d cycles",
               rising ? "rising" : "falling", sig_name(sel), limit);
      timeouts++;
    end
  endtask

  // length of the run that holds the current level
  task automatic count_run(input int sel, input int limit, output int cycles, output bit ended);
    logic start;
    start = sig_value(sel);
    cycles = 0;
    while (sig_value(sel) === start && cycles < limit)
    begin
      @(negedge pixclk);
      cycles++;
    end
    ended = (sig_value(sel) !== start);
    if (!ended)
    begin
      $display("timeout: %s held its level past %0d cycles", sig_name(sel), limit);
      timeouts++;
    end
  endtask

  // new inputs go in at the hsync fall well inside blanking
  task automatic apply_inputs(input logic sel, input rgb_t c);
    bit found;
    wait_edge(SEL_HSYNC, 1'b0, 2 * LINE_CYCLES, found);
    @(posedge pixclk);
    pattern_sel  <= sel;
    solid_colour <= c;
    @(negedge pixclk);
  endtask

  task automatic expect_idle(input string test);
    if (lcd_den !== 1'b0)
      report_mismatch({test, " den"}, 0, int'(lcd_den));
    if (lcd_hsync_n !== 1'b1)
      report_mismatch({test, " hsync_n"}, 1, int'(lcd_hsync_n));
    if (lcd_vsync_n !== 1'b1)
      report_mismatch({test, " vsync_n"}, 1, int'(lcd_vsync_n));
    if (lcd_dat !== 8'd0)
      report_mismatch({test, " dat"}, 0, int'(lcd_dat));
  endtask

  // called on the first den sample, which is the red byte of pixel 0
  // stops at the first bad byte to keep the log short
  task automatic check_line(input string test, input bit solid, input rgb_t c);
    logic [7:0] expected;
    bit bad;
    int i;
    bad = 1'b0;
    i = 0;
    while (!bad && i < ACTIVE_BYTES)
    begin
      if (solid)
        expected = (i % 3 == 0) ? c.red : (i % 3 == 1) ? c.green : c.blue;
      else
        expected = band_byte(i / 3, i % 3);
      if (lcd_den !== 1'b1)
      begin
        report_mismatch($sformatf("%s den at byte %0d", test, i), 1, int'(lcd_den));
        bad = 1'b1;
      end
      else if (lcd_dat !== expected)
      begin
        report_mismatch($sformatf("%s byte %0d", test, i), int'(expected), int'(lcd_dat));
        bad = 1'b1;
      end
      @(negedge pixclk);
      i++;
    end
    // bus must stay quiet in the horizontal blanking after the line
    i = 0;
    while (!bad && i < BLANK_BYTES)
    begin
      if (lcd_den !== 1'b0)
      begin
        report_mismatch($sformatf("%s blank den %0d", test, i), 0, int'(lcd_den));
        bad = 1'b1;
      end
      else if (lcd_dat !== 8'd0)
      begin
        report_mismatch($sformatf("%s blank dat %0d", test, i), 0, int'(lcd_dat));
        bad = 1'b1;
      end
      @(negedge pixclk);
      i++;
    end
  endtask

  // 4 reset edges and then the first edge after release
  task automatic reset_state();
    int i;
    for (i = 0; i < 3; i++)
    begin
      @(negedge pixclk);
      expect_idle("reset");
    end
    @(posedge pixclk);
    rst_n <= 1'b1;
    @(negedge pixclk);
    expect_idle("reset");
    @(negedge pixclk);
    expect_idle("reset_release");
  endtask

  task automatic line_timing();
    bit found;
    int low_cycles;
    int high_cycles;
    int den_cycles;
    int line;
    wait_edge(SEL_HSYNC, 1'b0, 2 * LINE_CYCLES, found);
    if (found)
      count_run(SEL_HSYNC, LINE_CYCLES, low_cycles, found);
    if (found)
      count_run(SEL_HSYNC, LINE_CYCLES, high_cycles, found);
    if (found)
    begin
      if (low_cycles != HSYNC_LOW)
        report_mismatch("line_timing hsync low", HSYNC_LOW, low_cycles);
      if (low_cycles + high_cycles != LINE_CYCLES)
        report_mismatch("line_timing period", LINE_CYCLES, low_cycles + high_cycles);
    end
    for (line = 0; line < 2; line++)
    begin
      wait_edge(SEL_DEN, 1'b1, FRAME_CYCLES, found);
      if (found)
        count_run(SEL_DEN, LINE_CYCLES, den_cycles, found);
      if (found && den_cycles != ACTIVE_BYTES)
        report_mismatch("line_timing den", ACTIVE_BYTES, den_cycles);
    end
  endtask

  // vsync fall to vsync fall while counting den lines
  // data must be 0 in every blank cycle of the frame
  task automatic frame_timing();
    bit found;
    bit done;
    bit dat_bad;
    logic prev_v;
    logic prev_den;
    int cycles;
    int low_cycles;
    int lines;
    wait_edge(SEL_VSYNC, 1'b0, FRAME_CYCLES + LINE_CYCLES, found);
    if (found)
    begin
      done = 1'b0;
      dat_bad = 1'b0;
      cycles = 0;
      low_cycles = 0;
      lines = 0;
      prev_v = lcd_vsync_n;
      prev_den = lcd_den;
      while (!done && cycles < FRAME_CYCLES + LINE_CYCLES)
      begin
        if (lcd_vsync_n === 1'b0)
          low_cycles++;
        if (!dat_bad && lcd_den === 1'b0 && lcd_dat !== 8'd0)
        begin
          report_mismatch($sformatf("frame_timing blank dat at cycle %0d", cycles),
                          0, int'(lcd_dat));
          dat_bad = 1'b1;
        end
        @(negedge pixclk);
        cycles++;
        if (lcd_den && !prev_den)
          lines++;
        if (prev_v && !lcd_vsync_n)
          done = 1'b1;
        prev_v = lcd_vsync_n;
        prev_den = lcd_den;
      end
      if (!done)
      begin
        $display("timeout: second vsync fall missing after %0d cycles", cycles);
        timeouts++;
      end
      else
      begin
        if (cycles != FRAME_CYCLES)
          report_mismatch("frame_timing period", FRAME_CYCLES, cycles);
        if (low_cycles != VSYNC_LOW)
          report_mismatch("frame_timing vsync low", VSYNC_LOW, low_cycles);
        if (lines != ACTIVE_LINES)
          report_mismatch("frame_timing den lines", ACTIVE_LINES, lines);
      end
    end
  endtask

  task automatic rainbow_line(input string test);
    bit found;
    int line;
    for (line = 0; line < 2; line++)
    begin
      wait_edge(SEL_DEN, 1'b1, FRAME_CYCLES, found);
      if (found)
        check_line(test, 1'b0, '0);
    end
  endtask

  task automatic solid_fill();
    rgb_t c;
    bit found;
    int k;
    for (k = 0; k < 3; k++)
    begin
      draw_colour(c);
      apply_inputs(1'b1, c);
      wait_edge(SEL_DEN, 1'b1, FRAME_CYCLES, found);
      if (found)
        check_line($sformatf("solid_fill %0d", k), 1'b1, c);
    end
  endtask

  // back to the rainbow with the colour input left as it was
  task automatic mode_return();
    apply_inputs(1'b0, solid_colour);
    rainbow_line("mode_return");
  endtask

  initial
  begin
    pixclk       = 1'b0;
    rst_n        = 1'b0;
    pattern_sel  = 1'b0;
    solid_colour = '0;
    lfsr_state   = 16'd72;
    errors       = 0;
    timeouts     = 0;
    reset_state();
    line_timing();
    frame_timing();
    rainbow_line("rainbow");
    solid_fill();
    mode_return();
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// File: lcd_panel.f
src/video_timing_pkg.sv
src/pixel_pkg.sv
src/lcd_timing_gen.sv
src/colour_channel.sv
src/lcd_serializer.sv
src/lcd_panel_top.sv
sim/tb_lcd_panel.sv

// File: run_sim.sh
#!/bin/sh
# build and run the LCD panel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_lcd_panel \
  -f lcd_panel.f \
  -o tb_lcd_panel
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_lcd_panel)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
  exit 0
fi
echo "simulation did not report a pass"
exit 1
